//--- dcache_pkg.sv
// Data cache shared definitions

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address layout and geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W       = 32;   // data and address width
    localparam int BYTE_OFF_W   = 2;    // byte within word
    localparam int BLK_OFF_W    = 1;    // word within block
    localparam int SETS_DEFAULT = 8;    // sets per way

    ////////////////////////////////////////////////////////////////////////////
    // common types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;  // data word or byte address

    typedef logic way_sel_t;            // way 0 or way 1

    typedef logic word_sel_t;           // word 0 or word 1 of a block

    // what the bus multiplexer puts on daddr and dstore
    typedef enum logic [1:0] {
        BUS_NONE,                       // bus idle
        BUS_WB,                         // victim writeback
        BUS_FILL,                       // block fill for the request
        BUS_FLUSH                       // flush of one stored word
    } bus_op_t;

endpackage

//--- dcache_way.sv
// Data cache way storage

`timescale 1ns/10ps

module dcache_way #(
    parameter int SETS = dcache_pkg::SETS_DEFAULT,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_pkg::WORD_W - IDX_W - dcache_pkg::BLK_OFF_W
                           - dcache_pkg::BYTE_OFF_W
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [IDX_W-1:0]      set_idx,
    input  logic [TAG_W-1:0]      tag,
    input  logic                  wen,
    input  dcache_pkg::word_sel_t wsel,
    input  dcache_pkg::word_t     wdata,
    input  logic                  tag_wen,
    input  logic                  dirty_set,
    input  logic                  dirty_clr,
    input  logic                  valid_clr,
    output logic                  hit,
    output logic [TAG_W-1:0]      cur_tag,
    output logic                  valid,
    output logic                  dirty,
    output dcache_pkg::word_t     word0,
    output dcache_pkg::word_t     word1
);

    logic [TAG_W-1:0]  tag_q   [SETS];
    dcache_pkg::word_t data0_q [SETS];
    dcache_pkg::word_t data1_q [SETS];
    logic [SETS-1:0]   valid_q;
    logic [SETS-1:0]   dirty_q;

    ////////////////////////////////////////////////////////////////////////////
    // status bits
    ////////////////////////////////////////////////////////////////////////////

    // all status changes ride on the word strobe of this way
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wen) begin
            if (valid_clr) begin
                valid_q[set_idx] <= 1'b0;                   // first fill word
            end else if (tag_wen) begin
                valid_q[set_idx] <= 1'b1;                   // last fill word
            end
            if (dirty_clr) begin
                dirty_q[set_idx] <= 1'b0;
            end else if (dirty_set) begin
                dirty_q[set_idx] <= 1'b1;                   // core store
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tags and data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (wen) begin
            if (wsel) begin
                data1_q[set_idx] <= wdata;
            end else begin
                data0_q[set_idx] <= wdata;
            end
            if (tag_wen) begin
                tag_q[set_idx] <= tag;
            end
        end
    end

    assign cur_tag = tag_q[set_idx];
    assign valid   = valid_q[set_idx];
    assign dirty   = dirty_q[set_idx];
    assign word0   = data0_q[set_idx];
    assign word1   = data1_q[set_idx];

    assign hit = valid && (cur_tag == tag);             // tag match on a live block

endmodule

//--- dcache_lru.sv
// Data cache replacement bits

`timescale 1ns/10ps

module dcache_lru #(
    parameter int SETS = dcache_pkg::SETS_DEFAULT,
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [IDX_W-1:0]     set_idx,
    input  logic                 access_hit,
    input  dcache_pkg::way_sel_t hit_way,
    output dcache_pkg::way_sel_t victim
);

    // one bit per set, naming the way to replace next
    logic [SETS-1:0] victim_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            victim_q <= '0;                                 // way 0 goes first
        end else if (access_hit) begin
            victim_q[set_idx] <= ~hit_way;                  // protect the way just used
        end
    end

    assign victim = victim_q[set_idx];

endmodule

//--- dcache_bus_mux.sv
// Data cache bus and load multiplexer

`timescale 1ns/10ps

module dcache_bus_mux #(
    parameter int SETS = dcache_pkg::SETS_DEFAULT,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_pkg::WORD_W - IDX_W - dcache_pkg::BLK_OFF_W
                           - dcache_pkg::BYTE_OFF_W
) (
    input  dcache_pkg::bus_op_t   bus_op,
    input  dcache_pkg::way_sel_t  victim,
    input  dcache_pkg::word_sel_t wsel,
    input  dcache_pkg::way_sel_t  flush_way,
    input  logic [IDX_W-1:0]      set_idx,
    input  logic [TAG_W-1:0]      req_tag,
    input  logic [TAG_W-1:0]      tag0,
    input  logic [TAG_W-1:0]      tag1,
    input  dcache_pkg::word_t     w00,
    input  dcache_pkg::word_t     w01,
    input  dcache_pkg::word_t     w10,
    input  dcache_pkg::word_t     w11,
    input  logic                  hit1,
    output dcache_pkg::word_t     daddr,
    output dcache_pkg::word_t     dstore,
    output dcache_pkg::word_t     dmemload
);

    dcache_pkg::way_sel_t src_way;
    logic [TAG_W-1:0]     src_tag;
    dcache_pkg::word_t    src_w0, src_w1;

    // way whose contents go out on the bus
    assign src_way = (bus_op == dcache_pkg::BUS_FLUSH) ? flush_way : victim;
    assign src_tag = src_way ? tag1 : tag0;
    assign src_w0  = src_way ? w10 : w00;
    assign src_w1  = src_way ? w11 : w01;

    always_comb begin
        daddr  = '0;
        dstore = '0;
        case (bus_op)
            dcache_pkg::BUS_WB, dcache_pkg::BUS_FLUSH: begin
                daddr  = {src_tag, set_idx, wsel, {dcache_pkg::BYTE_OFF_W{1'b0}}};
                dstore = wsel ? src_w1 : src_w0;
            end
            dcache_pkg::BUS_FILL: begin
                daddr = {req_tag, set_idx, wsel, {dcache_pkg::BYTE_OFF_W{1'b0}}};
            end
            default: begin
                daddr  = '0;                                // bus quiet
                dstore = '0;
            end
        endcase
    end

    // addressed word of the hitting way
    assign dmemload = hit1 ? (wsel ? w11 : w10) : (wsel ? w01 : w00);

endmodule

//--- dcache_ctrl.sv
// Data cache controller

`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int SETS = dcache_pkg::SETS_DEFAULT,
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  dmemREN,
    input  logic                  dmemWEN,
    input  logic                  halt,
    input  logic                  dwait,
    input  logic [IDX_W-1:0]      req_idx,
    input  dcache_pkg::word_sel_t req_wsel,
    input  logic                  hit0,
    input  logic                  hit1,
    input  logic                  valid0,
    input  logic                  valid1,
    input  logic                  dirty0,
    input  logic                  dirty1,
    input  dcache_pkg::way_sel_t  victim,
    output logic                  way_wen0,
    output logic                  way_wen1,
    output dcache_pkg::word_sel_t wsel,
    output logic                  fill_src,
    output logic                  tag_wen,
    output logic                  dirty_set,
    output logic                  dirty_clr,
    output logic                  valid_clr,
    output logic [IDX_W-1:0]      target_set,
    output dcache_pkg::way_sel_t  flush_way,
    output dcache_pkg::bus_op_t   bus_op,
    output logic                  dREN,
    output logic                  dWEN,
    output logic                  dhit,
    output logic                  flushed
);

    typedef enum logic [2:0] {S_IDLE, S_WB, S_FILL, S_FLUSH, S_DONE} state_t;

    state_t                state_q, state_d;
    dcache_pkg::word_sel_t word_q, word_d;      // word of the current transfer
    dcache_pkg::way_sel_t  fway_q, fway_d;      // way being flushed
    logic [IDX_W-1:0]      fset_q, fset_d;      // set being flushed
    logic                  req, hit, victim_dirty, flush_dirty;

    assign req          = dmemREN | dmemWEN;
    assign hit          = hit0 | hit1;
    assign victim_dirty = victim ? (valid1 & dirty1) : (valid0 & dirty0);
    assign flush_dirty  = fway_q ? (valid1 & dirty1) : (valid0 & dirty0);
    assign flush_way    = fway_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= S_IDLE;
            word_q  <= '0;
            fway_q  <= '0;
            fset_q  <= '0;
        end else begin
            state_q <= state_d;
            word_q  <= word_d;
            fway_q  <= fway_d;
            fset_q  <= fset_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        word_d     = word_q;
        fway_d     = fway_q;
        fset_d     = fset_q;
        way_wen0   = 1'b0;
        way_wen1   = 1'b0;
        wsel       = word_q;
        fill_src   = 1'b0;
        tag_wen    = 1'b0;
        dirty_set  = 1'b0;
        dirty_clr  = 1'b0;
        valid_clr  = 1'b0;
        target_set = req_idx;
        bus_op     = dcache_pkg::BUS_NONE;
        dREN       = 1'b0;
        dWEN       = 1'b0;
        dhit       = 1'b0;
        flushed    = 1'b0;

        case (state_q)
            S_IDLE: begin
                wsel = req_wsel;                            // core word on hits
                if (req && hit) begin
                    dhit      = 1'b1;
                    way_wen0  = dmemWEN & hit0;
                    way_wen1  = dmemWEN & hit1;
                    dirty_set = dmemWEN;
                end else if (req) begin
                    word_d  = '0;
                    state_d = victim_dirty ? S_WB : S_FILL;
                end else if (halt) begin
                    word_d  = '0;
                    fway_d  = '0;
                    fset_d  = '0;
                    state_d = S_FLUSH;
                end
            end
            S_WB: begin
                bus_op = dcache_pkg::BUS_WB;
                dWEN   = 1'b1;
                if (!dwait) begin
                    word_d = ~word_q;
                    if (word_q) begin
                        state_d = S_FILL;                   // victim written, now fetch
                    end
                end
            end
            S_FILL: begin
                bus_op   = dcache_pkg::BUS_FILL;
                dREN     = 1'b1;
                fill_src = 1'b1;
                if (!dwait) begin
                    way_wen0 = ~victim;
                    way_wen1 = victim;
                    word_d   = ~word_q;
                    if (word_q) begin
                        tag_wen = 1'b1;                     // block complete
                        state_d = S_IDLE;
                    end else begin
                        valid_clr = 1'b1;                   // old block gone
                        dirty_clr = 1'b1;
                    end
                end
            end
            S_FLUSH: begin
                bus_op     = dcache_pkg::BUS_FLUSH;
                target_set = fset_q;
                dWEN       = flush_dirty;
                // clean or invalid words step on without the bus
                if (!dwait || !flush_dirty) begin
                    word_d = ~word_q;
                    if (word_q) begin
                        fway_d = ~fway_q;
                        if (fway_q) begin
                            fset_d = fset_q + 1'b1;
                            if (fset_q == IDX_W'(SETS - 1)) begin
                                state_d = S_DONE;
                            end
                        end
                    end
                end
            end
            S_DONE: begin
                flushed = 1'b1;                             // held until reset
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

endmodule

//--- dcache.sv
// Data cache top level

`timescale 1ns/10ps

module dcache #(
    parameter int SETS = dcache_pkg::SETS_DEFAULT,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_pkg::WORD_W - IDX_W - dcache_pkg::BLK_OFF_W
                           - dcache_pkg::BYTE_OFF_W
) (
    input  logic              CLK,
    input  logic              nRST,
    // core side
    input  logic              dmemREN,
    input  logic              dmemWEN,
    input  logic              halt,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    output dcache_pkg::word_t dmemload,
    output logic              dhit,
    output logic              flushed,
    // memory side
    output logic              dREN,
    output logic              dWEN,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore,
    input  dcache_pkg::word_t dload,
    input  logic              dwait
);

    logic [TAG_W-1:0]      req_tag;
    logic [IDX_W-1:0]      req_idx;
    dcache_pkg::word_sel_t req_wsel;

    logic [IDX_W-1:0]      target_set;
    dcache_pkg::word_sel_t wsel;
    dcache_pkg::way_sel_t  victim;
    dcache_pkg::way_sel_t  flush_way;
    dcache_pkg::bus_op_t   bus_op;
    logic                  way_wen0, way_wen1;
    logic                  fill_src, tag_wen, dirty_set, dirty_clr, valid_clr;
    dcache_pkg::word_t     way_wdata;

    logic                  hit0, hit1;
    logic                  valid0, valid1, dirty0, dirty1;
    logic [TAG_W-1:0]      tag0, tag1;
    dcache_pkg::word_t     w00, w01, w10, w11;

    // request address fields
    assign req_tag  = dmemaddr[dcache_pkg::WORD_W-1 -: TAG_W];
    assign req_idx  = dmemaddr[dcache_pkg::BYTE_OFF_W + dcache_pkg::BLK_OFF_W +: IDX_W];
    assign req_wsel = dmemaddr[dcache_pkg::BYTE_OFF_W];

    assign way_wdata = fill_src ? dload : dmemstore;    // fill word or core store

    dcache_ctrl #(.SETS(SETS)) u_ctrl (
        .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .dwait,
        .req_idx, .req_wsel,
        .hit0, .hit1, .valid0, .valid1, .dirty0, .dirty1, .victim,
        .way_wen0, .way_wen1, .wsel, .fill_src, .tag_wen, .dirty_set,
        .dirty_clr, .valid_clr, .target_set, .flush_way, .bus_op,
        .dREN, .dWEN, .dhit, .flushed
    );

    dcache_way #(.SETS(SETS)) u_way0 (
        .CLK, .nRST, .set_idx(target_set), .tag(req_tag), .wen(way_wen0),
        .wsel, .wdata(way_wdata), .tag_wen, .dirty_set, .dirty_clr, .valid_clr,
        .hit(hit0), .cur_tag(tag0), .valid(valid0), .dirty(dirty0),
        .word0(w00), .word1(w01)
    );

    dcache_way #(.SETS(SETS)) u_way1 (
        .CLK, .nRST, .set_idx(target_set), .tag(req_tag), .wen(way_wen1),
        .wsel, .wdata(way_wdata), .tag_wen, .dirty_set, .dirty_clr, .valid_clr,
        .hit(hit1), .cur_tag(tag1), .valid(valid1), .dirty(dirty1),
        .word0(w10), .word1(w11)
    );

    dcache_lru #(.SETS(SETS)) u_lru (
        .CLK, .nRST, .set_idx(target_set), .access_hit(dhit), .hit_way(hit1),
        .victim
    );

    dcache_bus_mux #(.SETS(SETS)) u_bus_mux (
        .bus_op, .victim, .wsel, .flush_way, .set_idx(target_set),
        .req_tag, .tag0, .tag1, .w00, .w01, .w10, .w11, .hit1,
        .daddr, .dstore, .dmemload
    );

endmodule

//--- dcache_assert.sv
// Data cache bus assertions

`timescale 1ns/10ps

module dcache_assert (
    input logic              CLK,
    input logic              nRST,
    input logic              dmemREN,
    input logic              dmemWEN,
    input logic              dhit,
    input logic              flushed,
    input logic              dREN,
    input logic              dWEN,
    input logic              dwait,
    input dcache_pkg::word_t daddr,
    input dcache_pkg::word_t dstore
);

    int unsigned fail_cnt = 0;                              // failed checks so far

    // a stalled transfer keeps its request
    stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) && dwait |=> $stable({dREN, dWEN, daddr, dstore}))
        else begin
            $error("bus outputs changed while dwait was high");
            fail_cnt++;
        end

    one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else begin
            $error("dREN and dWEN high together");
            fail_cnt++;
        end

    flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else begin
            $error("flushed fell before reset");
            fail_cnt++;
        end

    hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> (dmemREN || dmemWEN))
        else begin
            $error("dhit high without a core request");
            fail_cnt++;
        end

endmodule

//--- tb_dcache.sv
// Data cache testbench

`timescale 1ns/10ps

module tb_dcache;

    localparam int SETS      = dcache_pkg::SETS_DEFAULT;
    localparam int MEM_WORDS = 1024;                        // 4 KB of modeled memory
    localparam int N_RAND    = 40;
    localparam int WAIT_N    = 512;                         // drawn dwait lengths
    localparam int WD_CYCLES = (N_RAND + 12) * 200 + 4 * SETS * 2 * 5 + 10;

    logic              CLK, nRST, dmemREN, dmemWEN, halt, dhit, flushed;
    logic              dREN, dWEN, dwait;
    dcache_pkg::word_t dmemaddr, dmemstore, dmemload, daddr, dstore, dload;
    dcache_pkg::word_t mem [MEM_WORDS];
    dcache_pkg::word_t shadow [MEM_WORDS];                  // last core write per word
    logic              written [MEM_WORDS] = '{default: 1'b0};
    logic              xfer_open = 1'b0;                    // memory transfer under way
    int unsigned       wait_left = 0;
    int unsigned       wait_len [WAIT_N];                   // dwait cycles per transfer
    int unsigned       n_xfer = 0;

    dcache #(.SETS(SETS)) u_dcache (.*);

    bind dcache dcache_assert u_assert (.*);

    function automatic dcache_pkg::word_t init_word(input int unsigned a);
        return 32'hC0DE_0000 ^ (a * 32'h0001_0001) ^ (a << 22);
    endfunction

    // latest value of a word as the core sees it
    function automatic dcache_pkg::word_t expect_word(input int unsigned i);
        return written[i] ? shadow[i] : mem[i];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge CLK);
        fail_now("timeout: the cache did not finish the test sequence in time");
    end

    always @(negedge CLK) begin
        if (u_dcache.u_assert.fail_cnt != 0) fail_now("a bus assertion on the cache failed");
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory model with 0 to 3 cycles of dwait per transfer
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (dREN || dWEN) begin
            if (!xfer_open) begin
                wait_left = wait_len[n_xfer % WAIT_N];
                n_xfer++;
                xfer_open = 1'b1;
            end else if (wait_left != 0) begin
                wait_left--;
            end
            dwait <= (wait_left != 0);
        end else begin
            dwait <= 1'b1;
        end
        dload <= mem[daddr[11:2]];
    end

    always @(posedge CLK) begin
        if ((dREN || dWEN) && !dwait) begin
            xfer_open = 1'b0;
            if (dWEN) begin                                 // writeback carries latest data
                assert (dstore == expect_word(daddr[11:2]))
                    else fail_now($sformatf("Error: dstore = %h, expected %h at daddr %h",
                                            dstore, expect_word(daddr[11:2]), daddr));
                mem[daddr[11:2]] = dstore;
            end
        end
    end

    // one core request held until dhit
    task automatic access(input logic we, input int unsigned i, input dcache_pkg::word_t data,
                          input logic must_hit);
        logic first;
        first = 1'b1;
        @(negedge CLK);
        dmemREN   = !we;
        dmemWEN   = we;
        dmemaddr  = dcache_pkg::word_t'(i) << 2;
        dmemstore = data;
        do begin
            @(posedge CLK);
            if (first && must_hit) begin
                assert (dhit && !dREN && !dWEN)
                    else fail_now($sformatf("Error: dhit/dREN/dWEN = %h/%h/%h, expected 1/0/0",
                                            dhit, dREN, dWEN));
            end
            first = 1'b0;
        end while (!dhit);
        if (we) begin
            shadow[i]  = data;
            written[i] = 1'b1;
        end else begin
            assert (dmemload == expect_word(i))
                else fail_now($sformatf("Error: dmemload = %h, expected %h at word %h",
                                        dmemload, expect_word(i), i));
        end
    endtask

    initial begin
        void'($urandom(98328));
        nRST      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        dload     = '0;
        dwait     = 1'b1;
        for (int k = 0; k < WAIT_N; k++)
            wait_len[k] = $urandom % 4;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = init_word(i);
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        access(1'b0, 'h21, '0, 1'b0);                       // read miss with a clean fill
        access(1'b0, 'h20, '0, 1'b1);
        access(1'b1, 'h20, 32'hDEAD_0020, 1'b1);            // write hit
        access(1'b0, 'h20, '0, 1'b1);
        assert (mem['h20] == init_word('h20))
            else fail_now($sformatf("Error: mem[20] = %h, expected %h",
                                    mem['h20], init_word('h20)));
        // three tags in set 0
        access(1'b0, 'h40, '0, 1'b0);                       // fills way 1
        access(1'b0, 'h20, '0, 1'b1);
        access(1'b0, 'h60, '0, 1'b0);                       // replaces tag 4
        access(1'b1, 'h61, 32'hBEEF_0061, 1'b1);
        access(1'b0, 'h20, '0, 1'b1);
        access(1'b0, 'h80, '0, 1'b0);                       // dirty tag 6 goes out first
        access(1'b0, 'h61, '0, 1'b0);                       // dirty tag 2 out and tag 6 back
        for (int n = 0; n < N_RAND; n++) begin
            access(1'($urandom % 2), $urandom % 256, $urandom, 1'b0);
        end

        @(negedge CLK);
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        halt    = 1'b1;
        while (!flushed) @(posedge CLK);
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (!written[i] || mem[i] == shadow[i])
                else fail_now($sformatf("Error: mem[%h] = %h, expected %h", i, mem[i], shadow[i]));
        end
        if (u_dcache.u_assert.fail_cnt != 0) begin
            fail_now("a bus assertion on the cache failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- dcache.f
dcache_pkg.sv
dcache_way.sv
dcache_lru.sv
dcache_bus_mux.sv
dcache_ctrl.sv
dcache.sv
dcache_assert.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_way.sv
  - dcache_lru.sv
  - dcache_bus_mux.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - dcache_assert.sv
      - tb_dcache.sv
